/* hdl/cen_pkg.sv */
// Package for the clock enable subsystem: widths, register map, divider and reset constants
package cen_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus and datapath widths
    //////////////////////////////////////////////////////////////////////

    localparam int apb_addr_w = 4;      // Byte offset within the register block
    localparam int apb_data_w = 32;
    localparam int acc_w      = 16;     // Accumulator, step and limit
    localparam int pcount_w   = 32;     // Fractional pulse counter

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    // Word-aligned offsets; anything else answers with pslverr
    typedef enum logic [apb_addr_w-1:0] {
        reg_ctrl   = 4'h0,              // Enable bits
        reg_step   = 4'h4,              // Accumulator step
        reg_limit  = 4'h8,              // Accumulator limit
        reg_pcount = 4'hC               // Pulse count, write clears
    } cen_reg_e;

    // Control register bit positions
    localparam int ctrl_bank_bit = 0;   // Fixed divider bank
    localparam int ctrl_frac_bit = 1;   // Fractional generator

    //////////////////////////////////////////////////////////////////////
    // Reset values and divider constants
    //////////////////////////////////////////////////////////////////////

    // 48 MHz * 105 / 1408 = 3.579545 MHz, the NTSC colour burst rate
    localparam logic [acc_w-1:0] step_reset  = 16'd105;
    localparam logic [acc_w-1:0] limit_reset = 16'd1408;

    // Last state of the modulo-six counter behind cen8 and cen4
    localparam logic [2:0] div6_last = 3'd5;

endpackage

/* hdl/cen_regs.sv */
// APB slave holding control, step, limit and fractional pulse-count registers
module cen_regs (
    input  logic                              clk,
    input  logic                              reset,
    // APB slave side
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [cen_pkg::apb_addr_w-1:0]    paddr,
    input  logic [cen_pkg::apb_data_w-1:0]    pwdata,
    output logic [cen_pkg::apb_data_w-1:0]    prdata,
    output logic                              pready,
    output logic                              pslverr,
    // Pulse to be counted
    input  logic                              cen_frac,
    // Generator controls
    output logic                              bank_en,
    output logic                              frac_en,
    output logic [cen_pkg::acc_w-1:0]         step,
    output logic [cen_pkg::acc_w-1:0]         limit,
    output logic                              frac_load
);

    logic                               access;     // Second cycle of a transfer
    logic                               addr_ok;    // Offset is a known register
    logic                               wr_en;      // Valid write, commits at this edge
    logic                               pcount_clr;
    logic [cen_pkg::apb_data_w-1:0]     rd_mux;
    logic [cen_pkg::pcount_w-1:0]       pcount;     // Pulses since last clear

    //////////////////////////////////////////////////////////////////////
    // Transfer decode
    //////////////////////////////////////////////////////////////////////

    assign access     = psel & penable;
    assign wr_en      = access & pwrite & addr_ok;
    assign pcount_clr = wr_en & (paddr == cen_pkg::reg_pcount);

    // Offset check and read data, zero for unknown offsets
    always_comb begin
        addr_ok = 1'b1;
        rd_mux  = '0;
        case (cen_pkg::cen_reg_e'(paddr))
            cen_pkg::reg_ctrl: begin
                rd_mux[cen_pkg::ctrl_bank_bit] = bank_en;
                rd_mux[cen_pkg::ctrl_frac_bit] = frac_en;
            end
            cen_pkg::reg_step:   rd_mux[cen_pkg::acc_w-1:0]    = step;
            cen_pkg::reg_limit:  rd_mux[cen_pkg::acc_w-1:0]    = limit;
            cen_pkg::reg_pcount: rd_mux[cen_pkg::pcount_w-1:0] = pcount;
            default:             addr_ok = 1'b0;    // Hole in the map
        endcase
    end

    // Zero wait states, data only in the access cycle of a read
    assign pready  = 1'b1;
    assign prdata  = (access & ~pwrite) ? rd_mux : '0;
    assign pslverr = access & ~addr_ok;

    //////////////////////////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_en   <= 1'b0;
            frac_en   <= 1'b0;
            step      <= cen_pkg::step_reset;
            limit     <= cen_pkg::limit_reset;
            frac_load <= 1'b0;
        end else begin
            frac_load <= 1'b0;                      // Strobe by default
            if (wr_en) begin
                case (cen_pkg::cen_reg_e'(paddr))
                    cen_pkg::reg_ctrl: begin
                        bank_en <= pwdata[cen_pkg::ctrl_bank_bit];
                        frac_en <= pwdata[cen_pkg::ctrl_frac_bit];
                    end
                    cen_pkg::reg_step: begin
                        step      <= pwdata[cen_pkg::acc_w-1:0];
                        frac_load <= 1'b1;          // Restart accumulator next cycle
                    end
                    cen_pkg::reg_limit: begin
                        limit     <= pwdata[cen_pkg::acc_w-1:0];
                        frac_load <= 1'b1;
                    end
                    default: ;                      // pcount handled below
                endcase
            end
        end
    end

    // Pulse counter, a clear wins over a coincident pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            pcount <= '0;
        end else if (pcount_clr) begin
            pcount <= '0;
        end else if (cen_frac) begin
            pcount <= pcount + cen_pkg::pcount_w'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Access phase never appears outside a selected transfer
    a_penable_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

    // Setup cycle is always followed by its access cycle
    a_setup_access: assert property (@(posedge clk) disable iff (reset)
        (psel && !penable) |=> (psel && penable));

    // Two-cycle transfers keep the reload strobe isolated
    a_load_single: assert property (@(posedge clk) disable iff (reset)
        frac_load |=> !frac_load);

endmodule

/* hdl/cen_div_bank.sv */
// Fixed-ratio clock enable bank: 12, 6, 3 MHz with 180 degree partners, plus 8 and 4 MHz
module cen_div_bank (
    input  logic clk,           // 48 MHz
    input  logic reset,
    input  logic bank_en,       // Counters hold while low
    output logic cen12,
    output logic cen12b,
    output logic cen6,
    output logic cen6b,
    output logic cen3,
    output logic cen3b,
    output logic cen8,
    output logic cen4
);

    logic [3:0] cnt;            // Free-running binary counter
    logic [2:0] cnt6;           // Modulo-six counter
    logic       tog;            // Halves the modulo-six rate
    logic       wrap6;

    assign wrap6 = (cnt6 == cen_pkg::div6_last);

    //////////////////////////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            cnt6 <= '0;
            tog  <= 1'b0;
        end else if (bank_en) begin
            cnt  <= cnt + 4'd1;
            cnt6 <= wrap6 ? 3'd0 : cnt6 + 3'd1;
            tog  <= tog ^ wrap6;                // Flips once per six cycles
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Registered decodes, one cycle behind the counters
    //////////////////////////////////////////////////////////////////////

    // Gated by bank_en so a held counter gives no pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            cen12  <= 1'b0;
            cen12b <= 1'b0;
            cen6   <= 1'b0;
            cen6b  <= 1'b0;
            cen3   <= 1'b0;
            cen3b  <= 1'b0;
            cen8   <= 1'b0;
            cen4   <= 1'b0;
        end else begin
            // Divide by 4
            cen12  <= bank_en && (cnt[1:0] == 2'd0);
            cen12b <= bank_en && (cnt[1:0] == 2'd2);    // Half period later
            // Divide by 8
            cen6   <= bank_en && (cnt[2:0] == 3'd0);
            cen6b  <= bank_en && (cnt[2:0] == 3'd4);
            // Divide by 16
            cen3   <= bank_en && (cnt == 4'h0);
            cen3b  <= bank_en && (cnt == 4'h8);
            // Divide by 6 and 12
            cen8   <= bank_en && (cnt6 == 3'd0);
            cen4   <= bank_en && (cnt6 == 3'd0) && tog;
        end
    end

endmodule

/* hdl/cen_frac.sv */
// Fractional clock enable phase accumulator with half-rate output and restart on bad state
module cen_frac (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        frac_en,
    input  logic                        frac_load,      // Step or limit just changed
    input  logic [cen_pkg::acc_w-1:0]   step,
    input  logic [cen_pkg::acc_w-1:0]   limit,
    output logic                        cen_frac,
    output logic                        cen_frac_half
);

    logic [cen_pkg::acc_w-1:0]  acc;        // Phase kept below limit in normal running
    logic                       half_phase; // Low when the next pulse also goes to half
    logic [cen_pkg::acc_w:0]    next_sum;   // One extra bit against overflow
    logic [cen_pkg::acc_w:0]    remainder;
    logic [cen_pkg::acc_w:0]    absmax;
    logic                       wrap;
    logic                       bad_acc;

    //////////////////////////////////////////////////////////////////////
    // Accumulator arithmetic
    //////////////////////////////////////////////////////////////////////

    assign next_sum  = {1'b0, acc} + {1'b0, step};
    assign remainder = next_sum - {1'b0, limit};   // Fraction carried past the wrap
    assign absmax    = {1'b0, limit} + {1'b0, step};
    assign wrap      = (next_sum >= {1'b0, limit});
    assign bad_acc   = ({1'b0, acc} > absmax);     // Unreachable in normal running

    //////////////////////////////////////////////////////////////////////
    // Phase and output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            acc           <= '0;
            half_phase    <= 1'b0;
            cen_frac      <= 1'b0;
            cen_frac_half <= 1'b0;
        end else if (frac_load || bad_acc) begin
            // Restart from zero phase so the next pulse counts as first
            acc           <= '0;
            half_phase    <= 1'b0;
            cen_frac      <= 1'b0;
            cen_frac_half <= 1'b0;
        end else if (frac_en && wrap) begin
            acc           <= remainder[cen_pkg::acc_w-1:0];
            cen_frac      <= 1'b1;
            cen_frac_half <= ~half_phase;   // First, third, fifth...
            half_phase    <= ~half_phase;
        end else begin
            if (frac_en) begin
                acc <= next_sum[cen_pkg::acc_w-1:0];
            end
            cen_frac      <= 1'b0;
            cen_frac_half <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Half-rate pulse is always a subset of the full-rate pulse
    a_half_subset: assert property (@(posedge clk) disable iff (reset)
        cen_frac_half |-> cen_frac);

endmodule

/* hdl/cen_top.sv */
// Top level of the clock enable subsystem: APB registers, fixed divider bank, fractional generator
module cen_top (
    input  logic                              clk,        // 48 MHz
    input  logic                              reset,
    // APB slave
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [cen_pkg::apb_addr_w-1:0]    paddr,
    input  logic [cen_pkg::apb_data_w-1:0]    pwdata,
    output logic [cen_pkg::apb_data_w-1:0]    prdata,
    output logic                              pready,
    output logic                              pslverr,
    // Fixed enables
    output logic                              cen12,
    output logic                              cen12b,
    output logic                              cen6,
    output logic                              cen6b,
    output logic                              cen3,
    output logic                              cen3b,
    output logic                              cen8,
    output logic                              cen4,
    // Fractional enables
    output logic                              cen_frac,
    output logic                              cen_frac_half
);

    logic                       bank_en;
    logic                       frac_en;
    logic                       frac_load;
    logic [cen_pkg::acc_w-1:0]  step;
    logic [cen_pkg::acc_w-1:0]  limit;

    //////////////////////////////////////////////////////////////////////
    // Register block
    //////////////////////////////////////////////////////////////////////

    cen_regs i_regs (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cen_frac  (cen_frac),      // Counted for rate measurement
        .bank_en   (bank_en),
        .frac_en   (frac_en),
        .step      (step),
        .limit     (limit),
        .frac_load (frac_load)
    );

    //////////////////////////////////////////////////////////////////////
    // Generators
    //////////////////////////////////////////////////////////////////////

    cen_div_bank i_div_bank (
        .clk     (clk),
        .reset   (reset),
        .bank_en (bank_en),
        .cen12   (cen12),
        .cen12b  (cen12b),
        .cen6    (cen6),
        .cen6b   (cen6b),
        .cen3    (cen3),
        .cen3b   (cen3b),
        .cen8    (cen8),
        .cen4    (cen4)
    );

    cen_frac i_frac (
        .clk           (clk),
        .reset         (reset),
        .frac_en       (frac_en),
        .frac_load     (frac_load),
        .step          (step),
        .limit         (limit),
        .cen_frac      (cen_frac),
        .cen_frac_half (cen_frac_half)
    );

endmodule

/* dv/cen_tb.sv */
// Clock enable subsystem testbench with clock, reset, APB driver, stimulus reader and monitors
module cen_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {rec_write, rec_read, rec_window} rec_kind_e;

    logic        clk;
    logic        reset;
    logic        psel, penable, pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready, pslverr;
    logic        cen12, cen12b, cen6, cen6b, cen3, cen3b, cen8, cen4;
    logic        cen_frac, cen_frac_half;
    logic [7:0]  fixed;                 // Fixed enables with cen12 in bit 0

    // Stimulus records
    rec_kind_e   kinds[$];
    logic [31:0] rec_a[$];              // Offset or window length
    logic [31:0] rec_d[$];
    logic [31:0] rec_e[$];
    int          win_exp[$];            // Eight counts per window

    logic [15:0] sh_step;               // Values as programmed
    logic [15:0] sh_limit;
    logic        sh_frac;

    int          frac_total;            // Since last pcount clear
    int          frac_since;            // Since last reload
    int          half_since;
    logic        skip_load;             // Next sample still from the old phase
    int          win_left;
    int          win_cycle;
    int          frac_win;
    int          win_count[8];
    int          last_seen[8];
    int          checks;
    int          errors;
    int          cycles;
    int          cycle_limit;
    logic [31:0] lfsr;

    string names[8]   = '{"cen12", "cen12b", "cen6", "cen6b", "cen3", "cen3b", "cen8", "cen4"};
    int    periods[8] = '{4, 4, 8, 8, 16, 16, 6, 12};

    assign fixed = {cen4, cen8, cen3b, cen3, cen6b, cen6, cen12b, cen12};

    cen_top i_dut (.*);

    always #10 clk = ~clk;              // 20 ns period

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: stimulus still running after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int idle_gap();
        int g;
        lfsr = lfsr_next(lfsr);
        g    = lfsr[0];
        lfsr = lfsr_next(lfsr);
        return g + 2 * lfsr[0];         // 0 to 3 cycles
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Pulse monitor sampling mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (skip_load) begin            // Reload lands on the next edge
            frac_since = 0;
            half_since = 0;
            skip_load  = 1'b0;
        end else begin
            frac_since += cen_frac;
            half_since += cen_frac_half;
        end
        frac_total += cen_frac;
        if (cen_frac_half)
            check_value("cen_frac under cen_frac_half", cen_frac, 1);
        if (win_left > 0) begin
            win_cycle++;
            frac_win += cen_frac;
            for (int i = 0; i < 8; i++) begin
                if (fixed[i]) begin
                    win_count[i]++;
                    if (last_seen[i] >= 0)
                        check_value({names[i], " period"}, win_cycle - last_seen[i], periods[i]);
                    if (i inside {1, 3, 5} && last_seen[i-1] >= 0)  // b after its partner
                        check_value({names[i], " offset"}, win_cycle - last_seen[i-1],
                                    periods[i] / 2);
                    last_seen[i] = win_cycle;
                end
            end
            win_left--;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Drivers
    //////////////////////////////////////////////////////////////////////

    task automatic apb_transfer(input logic wr, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        repeat (idle_gap() + 1) @(posedge clk);
        #2;
        psel    = 1'b1;                 // Setup cycle
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;                 // Access cycle
        @(negedge clk);
        check_value("pready", pready, 1'b1);    // No wait states
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);                 // Write commits here
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic run_window(input int n);
        int lo;
        for (int i = 0; i < 8; i++) begin
            win_count[i] = 0;
            last_seen[i] = -1;
        end
        frac_win  = 0;
        win_cycle = 0;
        @(posedge clk);
        #2;
        win_left = n;
        wait (win_left == 0);
        for (int i = 0; i < 8; i++)
            check_value({names[i], " count"}, win_count[i], win_exp.pop_front());
        // Rate bound floor(N*step/limit) plus at most one
        lo = sh_frac ? int'((longint'(n) * sh_step) / sh_limit) : 0;
        check_value("cen_frac count", frac_win,
                    (frac_win >= lo && frac_win <= lo + int'(sh_frac)) ? frac_win : lo);
        check_value("cen_frac_half total", half_since, (frac_since + 1) / 2);
    endtask

    task automatic load_stimulus(output logic ok);
        int          fd;
        int          c[8];
        logic [31:0] a, d, e;
        string       line;
        fd          = $fopen("dv/cen_stimulus.txt", "r");
        ok          = (fd != 0);
        cycle_limit = 100 + 3;          // Slack plus reset
        while (ok && $fgets(line, fd)) begin
            d = '0;
            e = '0;
            if (line.len() > 1 && line[0] inside {"W", "R", "N"}) begin
                if (line[0] == "W") begin
                    void'($sscanf(line, "W %h %h", a, d));
                    kinds.push_back(rec_write);
                end else if (line[0] == "R") begin
                    void'($sscanf(line, "R %h %h %h", a, d, e));
                    kinds.push_back(rec_read);
                end else begin
                    void'($sscanf(line, "N %d %d %d %d %d %d %d %d %d", a,
                                  c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7]));
                    kinds.push_back(rec_window);
                    foreach (c[i]) win_exp.push_back(c[i]);
                end
                rec_a.push_back(a);
                rec_d.push_back(d);
                rec_e.push_back(e);
                cycle_limit += (line[0] == "N") ? int'(a) : 6;
            end
        end
        if (ok) $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic        ok;
        logic        err;
        logic [31:0] rdata;
        int          err_before;
        clk        = 1'b0;
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr       = 32'h6d8c0355;
        sh_step    = cen_pkg::step_reset;
        sh_limit   = cen_pkg::limit_reset;
        sh_frac    = 1'b0;
        skip_load  = 1'b0;
        {frac_total, frac_since, half_since, win_left, checks, errors, cycles} = '0;
        load_stimulus(ok);
        if (!ok) begin
            $display("Stimulus file dv/cen_stimulus.txt could not be opened");
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            #2;
            reset = 1'b0;
            for (int r = 0; r < kinds.size(); r++) begin
                err_before = errors;
                case (kinds[r])
                    rec_write: begin
                        apb_transfer(1'b1, rec_a[r][3:0], rec_d[r], rdata, err);
                        check_value("pslverr", err, !(rec_a[r][3:0] inside {cen_pkg::reg_ctrl,
                                    cen_pkg::reg_step, cen_pkg::reg_limit, cen_pkg::reg_pcount}));
                        if (!err) begin
                            case (rec_a[r][3:0])
                                4'h0: sh_frac = rec_d[r][1];
                                4'h4: {sh_step, skip_load} = {rec_d[r][15:0], 1'b1};
                                4'h8: {sh_limit, skip_load} = {rec_d[r][15:0], 1'b1};
                                default: frac_total = 0;    // Count cleared
                            endcase
                        end
                    end
                    rec_read: begin
                        apb_transfer(1'b0, rec_a[r][3:0], '0, rdata, err);
                        check_value("prdata", rdata, (rec_a[r][3:0] == 4'hC && !rec_e[r][0]) ?
                                    frac_total : rec_d[r]);
                        check_value("pslverr", err, rec_e[r]);
                    end
                    default: run_window(rec_a[r]);
                endcase
                $display("Record %0d %s: %s", r, kinds[r].name(),
                         (errors == err_before) ? "pass" : "fail");
            end
            $display("Summary: %0d records, %0d checks, %0d errors", kinds.size(), checks, errors);
            if (errors == 0)
                $display("TEST OK");
            else
                $display("TEST FAILED");
            $finish;
        end
    end

endmodule

/* dv/cen_stimulus.txt */
# W <offset> <data>: write, hex. R <offset> <data> <pslverr>: read, hex, data unused at offset c
# N <cycles> <cen12 cen12b cen6 cen6b cen3 cen3b cen8 cen4>: window with pulse counts, decimal
# Reset state
N 20 0 0 0 0 0 0 0 0
R 0 00000000 0
R 4 00000069 0
R 8 00000580 0
# Register access and a hole in the map
W 4 0000007b
R 4 0000007b 0
W 8 00000601
R 8 00000601 0
W 1 12345678
R 1 00000000 1
R 8 00000601 0
W 0 00000001
R 0 00000001 0
# Fixed ratios with the bank alone
N 480 120 120 60 60 30 30 80 40
# Colour burst rate beside the bank
W 4 00000069
W 8 00000580
W c 00000000
W 0 00000003
R 0 00000003 0
N 960 240 240 120 120 60 60 160 80
W 0 00000002
R 0 00000002 0
N 96 0 0 0 0 0 0 0 0
# Pulse counter
W 0 00000000
R c 00000000 0
W c 00000000
R c 00000000 0
# Reprogramming to a tenth of the clock
W 4 00000100
W 8 00000a00
W 0 00000002
R 4 00000100 0
N 480 0 0 0 0 0 0 0 0
W 0 00000000
R c 00000000 0

/* files.f */
hdl/cen_pkg.sv
hdl/cen_regs.sv
hdl/cen_div_bank.sv
hdl/cen_frac.sv
hdl/cen_top.sv
dv/cen_tb.sv

/* Bender.yml */
package:
  name: cen

sources:
  - hdl/cen_pkg.sv
  - hdl/cen_regs.sv
  - hdl/cen_div_bank.sv
  - hdl/cen_frac.sv
  - hdl/cen_top.sv
  - target: simulation
    files:
      - dv/cen_tb.sv
